//--- rtl/core_pkg.sv
package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////
	typedef logic [31:0] word_t;        // Data word
	typedef logic [11:0] pc_t;          // Byte address into IMEM
	typedef logic [9:0]  imem_idx_t;    // Word index into IMEM
	typedef logic [9:0]  dm_addr_t;     // Word address into DMEM
	typedef logic [4:0]  reg_idx_t;     // Register number
	typedef logic [3:0]  byte_en_t;     // One bit per byte lane

	localparam int IMEM_DEPTH = 1024;
	localparam int DMEM_DEPTH = 1024;

	// Major opcodes of the kept subset
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	localparam word_t NOP_INST = 32'h0000_0013;   // ADDI x0,x0,0

	//////////////////////////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B     // LUI
	} alu_op_e;

	typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;

	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	//////////////////////////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic  valid;
		pc_t   pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    op_a;       // rs1 value read in decode
		word_t    op_b;       // rs2 value read in decode
		word_t    imm;
		alu_op_e  alu_op;
		logic     use_imm;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     is_branch;
		logic     branch_ne;  // BNE when set, else BEQ
		wb_sel_e  wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    alu_res;
		word_t    store_data;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		wb_sel_e  wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    wdata;
		logic     reg_write;
	} mem_wb_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                prog_we,
	input  core_pkg::imem_idx_t prog_addr,
	input  core_pkg::word_t     prog_data,
	input  logic                stall,
	input  logic                branch_taken,
	input  core_pkg::pc_t       branch_target,
	output core_pkg::if_id_t    if_id
);
	import core_pkg::*;

	word_t     imem [IMEM_DEPTH];   // Instruction RAM
	pc_t       pc;
	imem_idx_t fetch_idx;

	assign fetch_idx = pc[11:2];    // Drop byte offset

	// Program load from the testbench side
	always_ff @(posedge CLK) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// PC update
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;         // Redirect from execute
		end else if (!stall) begin
			pc <= pc + 12'd4;
		end
	end

	// IF/ID register
	always_ff @(posedge CLK) begin
		if (!rst_n || branch_taken) begin
			if_id.valid <= 1'b0;         // Bubble
			if_id.pc    <= '0;
			if_id.inst  <= NOP_INST;
		end else if (!stall) begin
			if_id.valid <= 1'b1;
			if_id.pc    <= pc;
			if_id.inst  <= imem[fetch_idx];
		end
		// Held while stalled
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic               CLK,
	input  logic               rst_n,
	input  core_pkg::if_id_t   if_id,
	input  logic               stall,
	input  logic               flush,
	input  core_pkg::word_t    rd_a,
	input  core_pkg::word_t    rd_b,
	output core_pkg::reg_idx_t rs_a,
	output core_pkg::reg_idx_t rs_b,
	output core_pkg::id_ex_t   id_ex
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_alt;     // Bit 30 picks SUB and SRA
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	id_ex_t     dec;            // Next ID/EX value
	logic       known;

	// ALU op from funct3, shared by R-type and I-type
	function automatic alu_op_e arith_op(logic [2:0] f3, logic alt, logic is_reg);
		case (f3)
			3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// Field split
	assign opcode     = if_id.inst[6:0];
	assign funct3     = if_id.inst[14:12];
	assign funct7_alt = if_id.inst[30];
	assign rs_a       = if_id.inst[19:15];
	assign rs_b       = if_id.inst[24:20];

	// Immediates, sign extended from bit 31
	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
		if_id.inst[30:25], if_id.inst[11:8], 1'b0};
	assign imm_u = {if_id.inst[31:12], 12'b0};

	always_comb begin
		dec        = '0;
		known      = 1'b1;
		dec.valid  = if_id.valid;
		dec.pc     = if_id.pc;
		dec.rs1    = rs_a;
		dec.rs2    = rs_b;
		dec.rd     = if_id.inst[11:7];
		dec.op_a   = rd_a;
		dec.op_b   = rd_b;          // Also the store data
		dec.alu_op = ALU_ADD;
		dec.wb_sel = WB_ALU;
		case (opcode)
			OP_RTYPE: begin
				dec.alu_op    = arith_op(funct3, funct7_alt, 1'b1);
				dec.reg_write = 1'b1;
			end
			OP_ITYPE: begin
				dec.alu_op    = arith_op(funct3, funct7_alt, 1'b0);
				dec.imm       = imm_i;    // Shamt sits in the low bits
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			OP_LUI: begin
				dec.alu_op    = ALU_PASS_B;
				dec.imm       = imm_u;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			OP_LOAD: begin
				known         = (funct3 == 3'b010);   // LW only
				dec.imm       = imm_i;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read  = 1'b1;
				dec.wb_sel    = WB_LOAD;
			end
			OP_STORE: begin
				known         = (funct3 == 3'b010);   // SW only
				dec.imm       = imm_s;
				dec.use_imm   = 1'b1;
				dec.mem_write = 1'b1;
			end
			OP_BRANCH: begin
				known         = (funct3[2:1] == 2'b00);  // BEQ and BNE
				dec.imm       = imm_b;
				dec.is_branch = 1'b1;
				dec.branch_ne = funct3[0];
			end
			default: known = 1'b0;
		endcase
	end

	// ID/EX register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (stall || flush || !known || !if_id.valid) begin
			id_ex <= '0;            // Bubble
		end else begin
			id_ex <= dec;
		end
	end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic               CLK,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t rs_a,
	input  core_pkg::reg_idx_t rs_b,
	output core_pkg::word_t    rd_a,
	output core_pkg::word_t    rd_b,
	input  core_pkg::mem_wb_t  wb
);
	import core_pkg::*;

	word_t regs [1:31];     // x0 has no storage
	logic  we;

	assign we = wb.valid && wb.reg_write && (wb.rd != '0);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wb.rd] <= wb.wdata;
		end
	end

	// Write-through reads
	assign rd_a = (rs_a == '0) ? '0 : (we && wb.rd == rs_a) ? wb.wdata : regs[rs_a];
	assign rd_b = (rs_b == '0) ? '0 : (we && wb.rd == rs_b) ? wb.wdata : regs[rs_b];

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
	input  core_pkg::id_ex_t   id_ex,
	input  core_pkg::ex_mem_t  ex_mem,
	input  core_pkg::mem_wb_t  mem_wb,
	input  core_pkg::reg_idx_t rs_a,      // Decode sources
	input  core_pkg::reg_idx_t rs_b,
	input  logic               branch_taken,
	output core_pkg::fwd_sel_e fwd_a,
	output core_pkg::fwd_sel_e fwd_b,
	output logic               stall,
	output logic               flush
);
	import core_pkg::*;

	logic mem_hit_ok;   // Memory stage result usable
	logic wb_hit_ok;
	logic load_in_ex;

	// Youngest producer first
	function automatic fwd_sel_e fwd_src(reg_idx_t rs, logic mem_ok, reg_idx_t mem_rd,
		logic wb_ok, reg_idx_t wb_rd);
		if (rs == '0) begin
			return FWD_REG;                 // x0 never forwarded
		end else if (mem_ok && mem_rd == rs) begin
			return FWD_MEM;
		end else if (wb_ok && wb_rd == rs) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// No forward from a load in memory
	// The load-use bubble keeps its consumer out of execute
	assign mem_hit_ok = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read;
	assign wb_hit_ok  = mem_wb.valid && mem_wb.reg_write;

	always_comb begin
		fwd_a = fwd_src(id_ex.rs1, mem_hit_ok, ex_mem.rd, wb_hit_ok, mem_wb.rd);
		fwd_b = fwd_src(id_ex.rs2, mem_hit_ok, ex_mem.rd, wb_hit_ok, mem_wb.rd);
	end

	// Load in execute feeding decode
	assign load_in_ex = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0);
	assign stall      = load_in_ex && (id_ex.rd == rs_a || id_ex.rd == rs_b);

	assign flush = branch_taken;     // Kill decode on redirect

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  logic               CLK,
	input  logic               rst_n,
	input  core_pkg::id_ex_t   id_ex,
	input  core_pkg::fwd_sel_e fwd_a,
	input  core_pkg::fwd_sel_e fwd_b,
	input  core_pkg::word_t    mem_fwd,
	input  core_pkg::word_t    wb_fwd,
	output logic               branch_taken,
	output core_pkg::pc_t      branch_target,
	output core_pkg::ex_mem_t  ex_mem
);
	import core_pkg::*;

	word_t opa;         // Forwarded rs1
	word_t rs2_val;     // Forwarded rs2
	word_t opb;         // ALU input B
	word_t alu_res;
	logic  equal;

	// Operand muxes
	always_comb begin
		case (fwd_a)
			FWD_MEM: opa = mem_fwd;
			FWD_WB:  opa = wb_fwd;
			default: opa = id_ex.op_a;
		endcase
		case (fwd_b)
			FWD_MEM: rs2_val = mem_fwd;
			FWD_WB:  rs2_val = wb_fwd;
			default: rs2_val = id_ex.op_b;
		endcase
	end

	assign opb = id_ex.use_imm ? id_ex.imm : rs2_val;

	// ALU
	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB:    alu_res = opa - opb;
			ALU_AND:    alu_res = opa & opb;
			ALU_OR:     alu_res = opa | opb;
			ALU_XOR:    alu_res = opa ^ opb;
			ALU_SLT:    alu_res = {31'b0, $signed(opa) < $signed(opb)};
			ALU_SLTU:   alu_res = {31'b0, opa < opb};
			ALU_SLL:    alu_res = opa << opb[4:0];
			ALU_SRL:    alu_res = opa >> opb[4:0];
			ALU_SRA:    alu_res = $signed(opa) >>> opb[4:0];
			ALU_PASS_B: alu_res = opb;      // LUI
			default:    alu_res = opa + opb;
		endcase
	end

	// BEQ / BNE on forwarded registers
	assign equal         = (opa == rs2_val);
	assign branch_taken  = id_ex.valid && id_ex.is_branch && (equal ^ id_ex.branch_ne);
	assign branch_target = id_ex.pc + id_ex.imm[11:0];

	// EX/MEM register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.alu_res    <= alu_res;
			ex_mem.store_data <= rs2_val;
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.wb_sel     <= id_ex.wb_sel;
		end
	end

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
	input  logic               CLK,
	input  logic               rst_n,
	input  core_pkg::ex_mem_t  ex_mem,
	input  core_pkg::byte_en_t con_write,
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::word_t    con_in,
	output core_pkg::word_t    con_out,
	output core_pkg::word_t    mem_fwd,
	output core_pkg::mem_wb_t  mem_wb
);
	import core_pkg::*;

	word_t    dmem [DMEM_DEPTH];    // Shared data RAM
	dm_addr_t core_addr;
	logic     con_hit;              // Controller writing the core's word
	logic     core_we;
	word_t    load_data;

	assign core_addr = ex_mem.alu_res[11:2];   // Word aligned access
	assign con_hit   = (con_write != '0) && (con_addr == core_addr);
	assign core_we   = ex_mem.valid && ex_mem.mem_write && !con_hit;  // Controller wins

	// Both ports read combinationally
	assign load_data = dmem[core_addr];
	assign con_out   = dmem[con_addr];

	assign mem_fwd = ex_mem.alu_res;

	always_ff @(posedge CLK) begin
		if (core_we) begin
			dmem[core_addr] <= ex_mem.store_data;    // Full word store
		end
		// Byte merge from the controller
		for (int i = 0; i < 4; i++) begin
			if (con_write[i]) begin
				dmem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			end
		end
	end

	// MEM/WB register with writeback mux
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.valid     <= ex_mem.valid;
			mem_wb.rd        <= ex_mem.rd;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.wdata     <= (ex_mem.wb_sel == WB_LOAD) ? load_data : ex_mem.alu_res;
		end
	end

endmodule

//--- rtl/core.sv
`timescale 1ns/100ps

module core (
	input  logic                CLK,
	input  logic                rst_n,
	// Program load port
	input  logic                prog_we,
	input  core_pkg::imem_idx_t prog_addr,
	input  core_pkg::word_t     prog_data,
	// Protocol controller port
	input  core_pkg::byte_en_t  con_write,
	input  core_pkg::dm_addr_t  con_addr,
	input  core_pkg::word_t     con_in,
	output core_pkg::word_t     con_out
);
	import core_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Stage links
	//////////////////////////////////////////////////////////////////////
	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;

	reg_idx_t rs_a, rs_b;         // Decode sources
	word_t    rd_a, rd_b;         // Regfile read data
	fwd_sel_e fwd_a, fwd_b;
	logic     stall;
	logic     flush;
	logic     branch_taken;
	pc_t      branch_target;
	word_t    mem_fwd;            // ALU result in memory stage

	//////////////////////////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////////////////////////
	fetch_stage i_fetch (.CLK, .rst_n, .prog_we, .prog_addr, .prog_data,
		.stall, .branch_taken, .branch_target, .if_id);

	decode_stage i_decode (.CLK, .rst_n, .if_id, .stall, .flush,
		.rd_a, .rd_b, .rs_a, .rs_b, .id_ex);

	regfile i_regfile (.CLK, .rst_n, .rs_a, .rs_b, .rd_a, .rd_b, .wb(mem_wb));

	hazard_unit i_hazard (.id_ex, .ex_mem, .mem_wb, .rs_a, .rs_b,
		.branch_taken, .fwd_a, .fwd_b, .stall, .flush);

	execute_stage i_execute (.CLK, .rst_n, .id_ex, .fwd_a, .fwd_b,
		.mem_fwd, .wb_fwd(mem_wb.wdata),       // Writeback data feeds back
		.branch_taken, .branch_target, .ex_mem);

	memory_stage i_memory (.CLK, .rst_n, .ex_mem, .con_write, .con_addr,
		.con_in, .con_out, .mem_fwd, .mem_wb);

endmodule

//--- dv/core_tb.sv
`timescale 1ns/100ps

module core_tb;
	import core_pkg::*;

	localparam int MAX_CYCLES = 3000;   // Four programs of ~300 cycles each plus margin
	localparam int RUN_LEN    = 200;    // Longest program plus drain
	// funct3 and bit 30 of every kept R-type op
	localparam logic [2:0] R_F3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
		3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
	localparam logic       R_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	localparam logic [2:0] I_F3  [9]  = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4,
		3'd5, 3'd5, 3'd6, 3'd7};
	localparam logic       I_ALT [9]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b1, 1'b0, 1'b0};    // SRAI only

	logic      clk = 1'b0;
	logic      rst_n;
	logic      prog_we;
	imem_idx_t prog_addr;
	word_t     prog_data;
	byte_en_t  con_write;
	dm_addr_t  con_addr;
	word_t     con_in;
	word_t     con_out;

	integer seed = 93971;
	int     cycle_count = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	word_t  program_q [$];          // Program being assembled

	core i_dut (.CLK(clk), .rst_n, .prog_we, .prog_addr, .prog_data,
		.con_write, .con_addr, .con_in, .con_out);

	always #20 clk = ~clk;          // 40 ns period

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run went past %0d cycles before the tests ended", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction encoders and reference model
	//////////////////////////////////////////////////////////////////////
	function automatic word_t rtype(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic word_t itype(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd);
		return {imm, rs1, f3, rd, OP_ITYPE};
	endfunction

	function automatic word_t lui_inst(reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic word_t lw_inst(reg_idx_t rd, reg_idx_t rs1, logic [11:0] off);
		return {off, rs1, 3'b010, rd, OP_LOAD};
	endfunction

	function automatic word_t sw_inst(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
		return {off[11:5], rs2, rs1, 3'b010, off[4:0], OP_STORE};
	endfunction

	// BEQ when ne is clear, BNE when set; off is a byte offset
	function automatic word_t branch_inst(logic ne, reg_idx_t rs1, reg_idx_t rs2, int off);
		logic [12:0] o;
		o = off[12:0];
		return {o[12], o[10:5], rs2, rs1, 2'b00, ne, o[4:1], o[11], OP_BRANCH};
	endfunction

	function automatic word_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I integer op result by funct3 and the bit-30 variant
	function automatic word_t rv32_arith(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic word_t byte_merge(word_t old_w, word_t new_w, byte_en_t be);
		word_t r;
		r = old_w;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) r[8*i +: 8] = new_w[8*i +: 8];
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus helpers and checks
	//////////////////////////////////////////////////////////////////////
	task automatic load_const(reg_idx_t rd, word_t val);
		word_t up;
		up = val + 32'h800;             // Round for the signed low part
		program_q.push_back(lui_inst(rd, up[31:12]));
		program_q.push_back(itype(val[11:0], rd, 3'd0, rd));
	endtask

	// Writes program_q with the core held in reset, then lets it run
	task automatic load_program();
		program_q.push_back(NOP_INST);  // Padding behind the halt loop
		program_q.push_back(NOP_INST);
		@(posedge clk);
		#2 rst_n = 1'b0;
		foreach (program_q[i]) begin
			prog_we   = 1'b1;
			prog_addr = imem_idx_t'(i);
			prog_data = program_q[i];
			@(posedge clk);
			#2;
		end
		prog_we = 1'b0;
		repeat (4) @(posedge clk);
		#2 rst_n = 1'b1;
		program_q.delete();
	endtask

	task automatic run_cycles();
		repeat (RUN_LEN) @(posedge clk);
	endtask

	task automatic write_con(dm_addr_t addr, byte_en_t be, word_t data);
		@(posedge clk);
		#2;
		con_addr  = addr;
		con_write = be;
		con_in    = data;
		@(posedge clk);                 // Lands on this edge
		#2 con_write = '0;
	endtask

	task automatic read_word(input dm_addr_t addr, output word_t data);
		@(posedge clk);
		#2 con_addr = addr;
		#10 data = con_out;             // Sampled mid-cycle
	endtask

	task automatic check_word(string name, word_t exp, word_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_bool(string name, logic exp, logic got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic end_test(string name, int errs_before);
		tests_run++;
		if (errors > errs_before) begin
			tests_failed++;
			$display("Test %s: %0d check(s) failed", name, errors - errs_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_con_port();
		int    e0;
		word_t exp;
		word_t got;
		word_t w;
		e0  = errors;
		exp = $random(seed);
		write_con(10'h3F0, 4'hF, exp);  // Full word first
		read_word(10'h3F0, got);
		check_word("con_out full write", exp, got);
		for (int k = 0; k < 3; k++) begin
			w   = $random(seed);
			exp = byte_merge(exp, w, (k == 0) ? 4'b0101 : (k == 1) ? 4'b1010 : 4'b0000);
			write_con(10'h3F0, (k == 0) ? 4'b0101 : (k == 1) ? 4'b1010 : 4'b0000, w);
			read_word(10'h3F0, got);
			check_word($sformatf("con_out partial write %0d", k), exp, got);
		end
		end_test("controller port", e0);
	endtask

	task automatic test_alu();
		int          e0;
		word_t       a;
		word_t       b;
		word_t       got;
		logic [11:0] imm;
		word_t       exp_q [$];
		e0 = errors;
		a  = $random(seed) | 32'h8000_0000;                 // Sign set to tell SRA from SRL
		b  = ($random(seed) & 32'h7FFF_FFFF) | 32'h1;      // Sign clear and nonzero shift
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 10; k++) begin
			program_q.push_back(rtype(R_ALT[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, R_F3[k], 5'd3));
			program_q.push_back(sw_inst(5'd3, 5'd0, 12'h100 + 12'(4 * k)));
			exp_q.push_back(rv32_arith(R_F3[k], R_ALT[k], a, b));
		end
		for (int j = 0; j < 9; j++) begin
			if (I_F3[j] == 3'd1 || I_F3[j] == 3'd5) begin
				imm = {1'b0, I_ALT[j], 5'b0, 5'($random(seed)) | 5'd1};   // Shamt form
			end else begin
				imm = 12'($random(seed));
			end
			program_q.push_back(itype(imm, 5'd1, I_F3[j], 5'd3));
			program_q.push_back(sw_inst(5'd3, 5'd0, 12'h100 + 12'(4 * (10 + j))));
			exp_q.push_back(rv32_arith(I_F3[j], I_ALT[j], a, sext12(imm)));
		end
		program_q.push_back(branch_inst(1'b0, 5'd0, 5'd0, 0));      // Halt
		load_program();
		run_cycles();
		foreach (exp_q[k]) begin
			read_word(10'h40 + 10'(k), got);
			check_word($sformatf("alu result %0d", k), exp_q[k], got);
		end
		end_test("alu operations", e0);
	endtask

	task automatic test_forwarding();
		int          e0;
		word_t       v;
		word_t       x2;
		word_t       x3;
		word_t       x5;
		word_t       got;
		logic [11:0] k1;
		e0 = errors;
		v  = $random(seed);
		k1 = 12'($random(seed));
		load_const(5'd1, v);
		program_q.push_back(rtype(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));   // Distance 1
		program_q.push_back(itype(k1, 5'd2, 3'd0, 5'd3));
		program_q.push_back(rtype(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));   // x2 at distance 2
		program_q.push_back(rtype(7'h00, 5'd2, 5'd4, 3'd4, 5'd5));   // x2 at distance 3
		program_q.push_back(rtype(7'h00, 5'd3, 5'd5, 3'd0, 5'd6));   // x3 at distance 3
		program_q.push_back(sw_inst(5'd6, 5'd0, 12'h200));
		program_q.push_back(branch_inst(1'b0, 5'd0, 5'd0, 0));
		load_program();
		run_cycles();
		x2 = v + v;
		x3 = x2 + sext12(k1);
		x5 = (x3 - x2) ^ x2;
		read_word(10'h80, got);
		check_word("forwarded chain", x5 + x3, got);
		end_test("forwarding", e0);
	endtask

	task automatic test_load_use();
		int    e0;
		word_t p;
		word_t q;
		word_t got;
		e0 = errors;
		p  = $random(seed);
		q  = $random(seed);
		write_con(10'h90, 4'hF, p);
		write_con(10'h91, 4'hF, q);
		program_q.push_back(lw_inst(5'd1, 5'd0, 12'h240));
		program_q.push_back(lw_inst(5'd2, 5'd0, 12'h244));
		program_q.push_back(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));   // Needs the bubble
		program_q.push_back(sw_inst(5'd3, 5'd0, 12'h248));
		program_q.push_back(lw_inst(5'd4, 5'd0, 12'h240));
		program_q.push_back(sw_inst(5'd4, 5'd0, 12'h24C));           // Load as store data
		program_q.push_back(branch_inst(1'b0, 5'd0, 5'd0, 0));
		load_program();
		run_cycles();
		read_word(10'h92, got);
		check_word("load-use sum", p + q, got);
		read_word(10'h93, got);
		check_word("load-use store data", p, got);
		end_test("load-use", e0);
	endtask

	task automatic test_branches();
		int    e0;
		int    n;
		word_t m [3];
		word_t got;
		e0 = errors;
		n  = 3 + ($random(seed) & 7);
		foreach (m[i]) begin
			m[i] = $random(seed);
			write_con(10'hC2 + 10'(i), 4'hF, m[i]);     // Markers
		end
		program_q.push_back(itype(12'(n), 5'd0, 3'd0, 5'd1));
		program_q.push_back(itype(12'd0, 5'd0, 3'd0, 5'd2));
		program_q.push_back(rtype(7'h00, 5'd1, 5'd2, 3'd0, 5'd2));   // Loop top
		program_q.push_back(itype(12'hFFF, 5'd1, 3'd0, 5'd1));
		program_q.push_back(branch_inst(1'b1, 5'd1, 5'd0, -8));
		program_q.push_back(sw_inst(5'd1, 5'd0, 12'h300));
		program_q.push_back(sw_inst(5'd2, 5'd0, 12'h304));
		program_q.push_back(branch_inst(1'b0, 5'd0, 5'd0, 12));      // Skips two stores
		program_q.push_back(sw_inst(5'd2, 5'd0, 12'h308));
		program_q.push_back(sw_inst(5'd2, 5'd0, 12'h30C));
		program_q.push_back(itype(12'd5, 5'd0, 3'd0, 5'd3));
		program_q.push_back(branch_inst(1'b0, 5'd3, 5'd0, 8));       // Not taken
		program_q.push_back(sw_inst(5'd3, 5'd0, 12'h310));
		program_q.push_back(branch_inst(1'b0, 5'd0, 5'd0, 0));
		load_program();
		run_cycles();
		read_word(10'hC0, got);
		check_word("loop final counter", 32'd0, got);
		read_word(10'hC1, got);
		check_word("loop sum", word_t'(n * (n + 1) / 2), got);
		read_word(10'hC2, got);
		check_bool("taken BEQ skipped store 0", 1'b1, got == m[0]);
		read_word(10'hC3, got);
		check_bool("taken BEQ skipped store 1", 1'b1, got == m[1]);
		read_word(10'hC4, got);
		check_bool("not-taken BEQ store landed", 1'b1, got != m[2]);
		check_word("not-taken BEQ store value", 32'd5, got);
		end_test("branches", e0);
	endtask

	initial begin
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		con_write = '0;
		con_addr  = '0;
		con_in    = '0;
		repeat (4) @(posedge clk);
		test_con_port();                // Core still held in reset
		test_alu();
		test_forwarding();
		test_load_use();
		test_branches();
		$display("%0d tests run, %0d failed, %0d of %0d checks failed",
			tests_run, tests_failed, errors, checks);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and check for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module core_tb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vcore_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" <<< "$sim_out"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
